/* common/mips_pkg.sv */
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_num_t;
    typedef logic [4:0] cp0_addr_t;

    typedef enum logic [4:0] {
        LW, LH, LHU, LB, LBU, SW, SH, SB,
        SYSCALL, BREAK, ERET, MTC0, MFC0, ALU, NOP
    } decoded_op_t;

    // Instruction leaving the memory stage
    typedef struct packed {
        logic        valid;
        decoded_op_t op;
        word_t       pcplus4;
        word_t       result;
        logic        memwrite;
        logic        memtoreg;
        logic        in_delay_slot;
        logic        exception_instr;
        logic        exception_instr_tlb;
        logic        exception_ri;
        logic        exception_of;
        reg_num_t    dest;
    } exec_data_t;

    ////////////////////////////////////////////////////////////////////////////
    // Exceptions
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic instr;
        logic instr_tlb;
        logic ri;
        logic of;
        logic sys;
        logic bp;
        logic load;
        logic save;
        logic load_tlb;
        logic save_tlb;
        logic mod;
        logic tr;
        logic cpu;
    } exc_info_t;

    typedef struct packed {
        exc_info_t  exc_info;
        logic [7:0] interrupt_info;
        logic       in_delay_slot;
        word_t      pc;
        word_t      vaddr;
    } exception_pipeline_t;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    typedef struct packed {
        exc_code_t code;
        logic      badvaddr_valid;
        word_t     badvaddr;
    } exception_t;

    localparam word_t EXC_VECTOR = 32'hBFC00380;

    ////////////////////////////////////////////////////////////////////////////
    // Coprocessor 0
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  IM;
        logic [5:0]  rsvd_lo;
        logic        EXL;
        logic        IE;
    } cp0_status_t;

    typedef struct packed {
        logic        BD;
        logic        TI;
        logic [13:0] rsvd_hi;
        logic [7:0]  IP;
        logic        rsvd_mid;
        exc_code_t   ExcCode;
        logic [1:0]  rsvd_lo;
    } cp0_cause_t;

    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

endpackage

/* common/exc_report_if.sv */
`timescale 1ns/1ps

interface exc_report_if;

    logic                valid;
    mips_pkg::exc_code_t code;
    mips_pkg::word_t     epc;
    logic                in_delay_slot;
    mips_pkg::word_t     badvaddr;
    logic                badvaddr_valid;

    modport reporter (
        output valid, code, epc, in_delay_slot, badvaddr, badvaddr_valid
    );

    // Sampled on the edge where valid is high
    modport recorder (
        input valid, code, epc, in_delay_slot, badvaddr, badvaddr_valid
    );

endinterface

/* exception/exception_priority.sv */
`timescale 1ns/1ps

module exception_priority (
    input  mips_pkg::exception_pipeline_t pipe,
    input  mips_pkg::cp0_status_t         cp0_status,
    output logic                          exception_valid,
    output mips_pkg::word_t               pcexception,
    output mips_pkg::exception_t          exception
);

    logic interrupt_taken;

    assign interrupt_taken = (|pipe.interrupt_info) && cp0_status.IE && !cp0_status.EXL;

    // Fixed priority, interrupt first
    always_comb begin
        exception       = '0;
        exception_valid = 1'b1;
        if (interrupt_taken) begin
            exception.code = mips_pkg::INT;
        end else if (pipe.exc_info.instr) begin
            exception.code           = mips_pkg::ADEL;
            exception.badvaddr_valid = 1'b1;
            exception.badvaddr       = pipe.pc;
        end else if (pipe.exc_info.instr_tlb) begin
            exception.code           = mips_pkg::TLBL;
            exception.badvaddr_valid = 1'b1;
            exception.badvaddr       = pipe.pc;
        end else if (pipe.exc_info.ri) begin
            exception.code = mips_pkg::RI;
        end else if (pipe.exc_info.of) begin
            exception.code = mips_pkg::OV;
        end else if (pipe.exc_info.sys) begin
            exception.code = mips_pkg::SYS;
        end else if (pipe.exc_info.bp) begin
            exception.code = mips_pkg::BP;
        end else if (pipe.exc_info.load) begin
            exception.code           = mips_pkg::ADEL;
            exception.badvaddr_valid = 1'b1;
            exception.badvaddr       = pipe.vaddr;
        end else if (pipe.exc_info.save) begin
            exception.code           = mips_pkg::ADES;
            exception.badvaddr_valid = 1'b1;
            exception.badvaddr       = pipe.vaddr;
        end else if (pipe.exc_info.load_tlb) begin
            exception.code           = mips_pkg::TLBL;
            exception.badvaddr_valid = 1'b1;
            exception.badvaddr       = pipe.vaddr;
        end else if (pipe.exc_info.save_tlb) begin
            exception.code           = mips_pkg::TLBS;
            exception.badvaddr_valid = 1'b1;
            exception.badvaddr       = pipe.vaddr;
        end else if (pipe.exc_info.mod) begin
            exception.code           = mips_pkg::MOD;
            exception.badvaddr_valid = 1'b1;
            exception.badvaddr       = pipe.vaddr;
        end else begin
            exception_valid = 1'b0;
        end
    end

    assign pcexception = exception_valid ? mips_pkg::EXC_VECTOR : '0;

endmodule

/* exception/exception_checker.sv */
`timescale 1ns/1ps

module exception_checker (
    input  logic                           rst,
    input  logic                           flush,
    input  mips_pkg::exec_data_t           exe,
    input  logic [5:0]                     ext_int,
    input  logic                           d_tlb_invalid,
    input  logic                           tlb_modified,
    input  mips_pkg::cp0_status_t          cp0_status,
    input  mips_pkg::cp0_cause_t           cp0_cause,
    output logic                           exception_valid,
    output mips_pkg::word_t                pcexception,
    output mips_pkg::exc_code_t            exception_code,
    output mips_pkg::exec_data_t           mem_out,
    exc_report_if.reporter                 rpt
);

    mips_pkg::exec_data_t          data;
    mips_pkg::exception_pipeline_t pipe;
    mips_pkg::exception_t          exc;
    mips_pkg::word_t               pc_vector;
    logic                          raw_valid;
    logic                          active;
    logic                          load_misaligned;
    logic                          save_misaligned;

    assign data   = rst ? '0 : exe;
    assign active = !flush && data.valid;

    ////////////////////////////////////////////////////////////////////////////
    // Fault vector
    ////////////////////////////////////////////////////////////////////////////

    assign load_misaligned = (data.op == mips_pkg::LW && data.result[1:0] != 2'b00) ||
                             ((data.op == mips_pkg::LH || data.op == mips_pkg::LHU) &&
                              data.result[0]);
    assign save_misaligned = (data.op == mips_pkg::SW && data.result[1:0] != 2'b00) ||
                             (data.op == mips_pkg::SH && data.result[0]);

    assign pipe.exc_info.instr     = data.exception_instr;
    assign pipe.exc_info.instr_tlb = data.exception_instr_tlb;
    assign pipe.exc_info.ri        = data.exception_ri;
    assign pipe.exc_info.of        = data.exception_of;
    assign pipe.exc_info.sys       = (data.op == mips_pkg::SYSCALL);
    assign pipe.exc_info.bp        = (data.op == mips_pkg::BREAK);
    assign pipe.exc_info.load      = load_misaligned;
    assign pipe.exc_info.save      = save_misaligned;
    // Data TLB response only matters for an actual access
    assign pipe.exc_info.load_tlb  = d_tlb_invalid & data.memtoreg;
    assign pipe.exc_info.save_tlb  = d_tlb_invalid & data.memwrite;
    assign pipe.exc_info.mod       = tlb_modified & data.memwrite;
    assign pipe.exc_info.tr        = 1'b0;
    assign pipe.exc_info.cpu       = 1'b0;

    assign pipe.in_delay_slot  = data.in_delay_slot;
    assign pipe.pc             = data.pcplus4 - 32'd4;
    assign pipe.vaddr          = data.exception_instr ? pipe.pc : data.result;
    assign pipe.interrupt_info = ({ext_int, 2'b00} | cp0_cause.IP | {cp0_cause.TI, 7'b0}) &
                                 cp0_status.IM;

    exception_priority u_priority (
        .pipe            (pipe),
        .cp0_status      (cp0_status),
        .exception_valid (raw_valid),
        .pcexception     (pc_vector),
        .exception       (exc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Outputs, gated by flush and valid
    ////////////////////////////////////////////////////////////////////////////

    assign exception_valid = active && raw_valid;
    assign pcexception     = active ? pc_vector : '0;
    assign exception_code  = active ? exc.code : mips_pkg::INT;
    assign mem_out         = (active && !raw_valid) ? data : '0;

    assign rpt.valid          = exception_valid;
    assign rpt.code           = exception_code;
    assign rpt.epc            = pipe.in_delay_slot ? pipe.pc - 32'd4 : pipe.pc;
    assign rpt.in_delay_slot  = pipe.in_delay_slot;
    assign rpt.badvaddr       = exc.badvaddr;
    assign rpt.badvaddr_valid = active && exc.badvaddr_valid;

endmodule

/* verilog/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs #(
    parameter int TIMER_DIV = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  eret,
    input  logic                  we,
    input  mips_pkg::cp0_addr_t   addr,
    input  mips_pkg::word_t       wdata,
    exc_report_if.recorder        rpt,
    output mips_pkg::word_t       rdata,
    output mips_pkg::cp0_status_t status,
    output mips_pkg::cp0_cause_t  cause,
    output mips_pkg::word_t       epc
);

    localparam int PW = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

    mips_pkg::word_t badvaddr_q;
    mips_pkg::word_t count_q;
    mips_pkg::word_t compare_q;
    logic [PW-1:0]   presc_q;
    logic            tick;
    logic            wr;

    // An exception in the same cycle drops the write and the eret
    assign wr   = we && !rpt.valid;
    assign tick = (presc_q == PW'(TIMER_DIV - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Timer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            presc_q   <= '0;
            count_q   <= '0;
            compare_q <= '0;
            cause.TI  <= 1'b0;
        end else begin
            presc_q <= tick ? '0 : presc_q + 1'b1;
            if (wr && addr == mips_pkg::CP0_COUNT) begin
                count_q <= wdata;
            end else if (tick) begin
                count_q <= count_q + 32'd1;
            end
            if (wr && addr == mips_pkg::CP0_COMPARE) begin
                compare_q <= wdata;
                cause.TI  <= 1'b0;
            end else if (tick && count_q + 32'd1 == compare_q) begin
                cause.TI <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Status, Cause, EPC, BadVAddr
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            status       <= '0;
            cause.BD     <= 1'b0;
            cause.IP     <= '0;
            cause.ExcCode <= mips_pkg::INT;
            epc          <= '0;
            badvaddr_q   <= '0;
        end else if (rpt.valid) begin
            status.EXL    <= 1'b1;
            cause.BD      <= rpt.in_delay_slot;
            cause.ExcCode <= rpt.code;
            epc           <= rpt.epc;
            if (rpt.badvaddr_valid) begin
                badvaddr_q <= rpt.badvaddr;
            end
        end else begin
            if (eret) begin
                status.EXL <= 1'b0;
            end
            if (wr && addr == mips_pkg::CP0_STATUS) begin
                status.IM <= wdata[15:8];
                status.IE <= wdata[0];
            end
            // Only the two software interrupt bits are writable
            if (wr && addr == mips_pkg::CP0_CAUSE) begin
                cause.IP[1:0] <= wdata[9:8];
            end
            if (wr && addr == mips_pkg::CP0_EPC) begin
                epc <= wdata;
            end
        end
    end

    // Reserved fields read as zero
    assign cause.rsvd_hi  = '0;
    assign cause.rsvd_mid = 1'b0;
    assign cause.rsvd_lo  = '0;

    always_comb begin
        case (addr)
            mips_pkg::CP0_BADVADDR: rdata = badvaddr_q;
            mips_pkg::CP0_COUNT:    rdata = count_q;
            mips_pkg::CP0_COMPARE:  rdata = compare_q;
            mips_pkg::CP0_STATUS:   rdata = status;
            mips_pkg::CP0_CAUSE:    rdata = cause;
            mips_pkg::CP0_EPC:      rdata = epc;
            default:                rdata = '0;
        endcase
    end

    eret_outside_handler: assert property (
        @(posedge clk) disable iff (rst) !(eret && rpt.valid && !status.EXL)
    ) else $warning("eret coincides with a new exception outside a handler");

endmodule

/* verilog/exc_unit_top.sv */
`timescale 1ns/1ps

module exc_unit_top #(
    parameter int TIMER_DIV = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  mips_pkg::exec_data_t exe,
    input  logic [5:0]           ext_int,
    input  logic                 d_tlb_invalid,
    input  logic                 tlb_modified,
    input  logic                 cp0_we,
    input  mips_pkg::cp0_addr_t  cp0_addr,
    input  mips_pkg::word_t      cp0_wdata,
    input  logic                 eret,
    output logic                 exception_valid,
    output mips_pkg::word_t      pcexception,
    output mips_pkg::exc_code_t  exception_code,
    output mips_pkg::exec_data_t mem_out,
    output mips_pkg::word_t      cp0_rdata,
    output mips_pkg::word_t      epc,
    output logic                 status_exl
);

    mips_pkg::cp0_status_t status;
    mips_pkg::cp0_cause_t  cause;

    exc_report_if rpt ();

    exception_checker u_checker (
        .rst             (rst),
        .flush           (flush),
        .exe             (exe),
        .ext_int         (ext_int),
        .d_tlb_invalid   (d_tlb_invalid),
        .tlb_modified    (tlb_modified),
        .cp0_status      (status),
        .cp0_cause       (cause),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .exception_code  (exception_code),
        .mem_out         (mem_out),
        .rpt             (rpt.reporter)
    );

    cp0_regs #(
        .TIMER_DIV (TIMER_DIV)
    ) u_cp0 (
        .clk    (clk),
        .rst    (rst),
        .eret   (eret),
        .we     (cp0_we),
        .addr   (cp0_addr),
        .wdata  (cp0_wdata),
        .rpt    (rpt.recorder),
        .rdata  (cp0_rdata),
        .status (status),
        .cause  (cause),
        .epc    (epc)
    );

    assign status_exl = status.EXL;

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

/* sim/exc_unit_tb.sv */
`timescale 1ns/1ps

module exc_unit_tb;

    localparam int TIMER_DIV  = 2;
    localparam int MAX_CYCLES = 4000;
    localparam int TIMER_N    = 10;

    typedef struct packed {
        logic                valid;
        mips_pkg::exc_code_t code;
        mips_pkg::word_t     vector;
        logic                bv_valid;
        mips_pkg::word_t     badvaddr;
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    mips_pkg::exec_data_t exe;
    logic [5:0]           ext_int;
    logic                 d_tlb_invalid;
    logic                 tlb_modified;
    logic                 cp0_we;
    mips_pkg::cp0_addr_t  cp0_addr;
    mips_pkg::word_t      cp0_wdata;
    logic                 eret;
    logic                 exception_valid;
    mips_pkg::word_t      pcexception;
    mips_pkg::exc_code_t  exception_code;
    mips_pkg::exec_data_t mem_out;
    mips_pkg::word_t      cp0_rdata;
    mips_pkg::word_t      epc;
    logic                 status_exl;

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;

    // Model of the CP0 registers as of the coming edge
    logic [7:0]          m_im = '0;
    logic                m_ie = 1'b0;
    logic                m_exl = 1'b0;
    logic [1:0]          m_ip = '0;
    logic                m_ti = 1'b0;
    logic                m_bd = 1'b0;
    mips_pkg::exc_code_t m_code = mips_pkg::INT;
    mips_pkg::word_t     m_epc = '0;
    mips_pkg::word_t     m_badvaddr = '0;
    mips_pkg::word_t     m_count = '0;
    mips_pkg::word_t     m_compare = '0;
    int                  m_presc = 0;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(8)) u_clock (.clk(clk), .rst(rst));

    exc_unit_top #(.TIMER_DIV(TIMER_DIV)) DUT (
        .clk(clk), .rst(rst), .flush(flush), .exe(exe), .ext_int(ext_int),
        .d_tlb_invalid(d_tlb_invalid), .tlb_modified(tlb_modified),
        .cp0_we(cp0_we), .cp0_addr(cp0_addr), .cp0_wdata(cp0_wdata), .eret(eret),
        .exception_valid(exception_valid), .pcexception(pcexception),
        .exception_code(exception_code), .mem_out(mem_out), .cp0_rdata(cp0_rdata),
        .epc(epc), .status_exl(status_exl)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic expect_t reference_outputs(input mips_pkg::exec_data_t x,
                                                  input logic fl, input logic [5:0] ints,
                                                  input logic tlb_inv, input logic tlb_mod);
        expect_t         r;
        mips_pkg::word_t pc;
        logic            load_f;
        logic            save_f;
        logic [7:0]      pending;
        r       = '0;
        pc      = x.pcplus4 - 32'd4;
        load_f  = (x.op == mips_pkg::LW && x.result[1:0] != 2'b00) ||
                  ((x.op == mips_pkg::LH || x.op == mips_pkg::LHU) && x.result[0]);
        save_f  = (x.op == mips_pkg::SW && x.result[1:0] != 2'b00) ||
                  (x.op == mips_pkg::SH && x.result[0]);
        pending = ({ints, 2'b00} | {6'b0, m_ip} | {m_ti, 7'b0}) & m_im;
        r.valid = 1'b1;
        if (fl || !x.valid) begin
            r.valid = 1'b0;
        end else if (|pending && m_ie && !m_exl) begin
            r.code = mips_pkg::INT;
        end else if (x.exception_instr) begin
            r.code = mips_pkg::ADEL;
            r.bv_valid = 1'b1;
            r.badvaddr = pc;
        end else if (x.exception_instr_tlb) begin
            r.code = mips_pkg::TLBL;
            r.bv_valid = 1'b1;
            r.badvaddr = pc;
        end else if (x.exception_ri) begin
            r.code = mips_pkg::RI;
        end else if (x.exception_of) begin
            r.code = mips_pkg::OV;
        end else if (x.op == mips_pkg::SYSCALL) begin
            r.code = mips_pkg::SYS;
        end else if (x.op == mips_pkg::BREAK) begin
            r.code = mips_pkg::BP;
        end else if (load_f || save_f || (tlb_inv && (x.memtoreg || x.memwrite)) ||
                     (tlb_mod && x.memwrite)) begin
            r.bv_valid = 1'b1;
            r.badvaddr = x.result;
            if (load_f)
                r.code = mips_pkg::ADEL;
            else if (save_f)
                r.code = mips_pkg::ADES;
            else if (tlb_inv && x.memtoreg)
                r.code = mips_pkg::TLBL;
            else if (tlb_inv)
                r.code = mips_pkg::TLBS;
            else
                r.code = mips_pkg::MOD;
        end else begin
            r.valid = 1'b0;
        end
        if (r.valid)
            r.vector = mips_pkg::EXC_VECTOR;
        return r;
    endfunction

    function automatic mips_pkg::word_t cp0_read(input mips_pkg::cp0_addr_t a);
        case (a)
            mips_pkg::CP0_BADVADDR: return m_badvaddr;
            mips_pkg::CP0_COUNT:    return m_count;
            mips_pkg::CP0_COMPARE:  return m_compare;
            mips_pkg::CP0_STATUS:   return {16'h0, m_im, 6'h0, m_exl, m_ie};
            mips_pkg::CP0_CAUSE:    return {m_bd, m_ti, 20'h0, m_ip, 1'b0, m_code, 2'b00};
            mips_pkg::CP0_EPC:      return m_epc;
            default:                return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %0h expected %0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // Outputs are settled mid-cycle, then the model steps past the next edge
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        logic    wr;
        logic    tick;
        e = reference_outputs(exe, flush, ext_int, d_tlb_invalid, tlb_modified);
        if (!rst) begin
            check_value("exception_valid", exception_valid, e.valid);
            check_value("exception_code", exception_code, e.code);
            check_value("pcexception", pcexception, e.vector);
            check_value("mem_out", mem_out, (!flush && exe.valid && !e.valid) ? exe : '0);
            check_value("epc", epc, m_epc);
            check_value("status_exl", status_exl, m_exl);
            check_value("cp0_rdata", cp0_rdata, cp0_read(cp0_addr));
        end
        if (rst) begin
            m_im = '0;
            m_ie = 1'b0;
            m_exl = 1'b0;
            m_ip = '0;
            m_ti = 1'b0;
            m_bd = 1'b0;
            m_code = mips_pkg::INT;
            m_epc = '0;
            m_badvaddr = '0;
            m_count = '0;
            m_compare = '0;
            m_presc = 0;
        end else begin
            wr = cp0_we && !e.valid;
            tick = (m_presc == TIMER_DIV - 1);
            if (e.valid) begin
                m_exl = 1'b1;
                m_bd = exe.in_delay_slot;
                m_code = e.code;
                m_epc = exe.pcplus4 - (exe.in_delay_slot ? 32'd8 : 32'd4);
                if (e.bv_valid)
                    m_badvaddr = e.badvaddr;
            end else begin
                if (eret)
                    m_exl = 1'b0;
                if (wr && cp0_addr == mips_pkg::CP0_STATUS) begin
                    m_im = cp0_wdata[15:8];
                    m_ie = cp0_wdata[0];
                end
                if (wr && cp0_addr == mips_pkg::CP0_CAUSE)
                    m_ip = cp0_wdata[9:8];
                if (wr && cp0_addr == mips_pkg::CP0_EPC)
                    m_epc = cp0_wdata;
            end
            if (wr && cp0_addr == mips_pkg::CP0_COMPARE) begin
                m_compare = cp0_wdata;
                m_ti = 1'b0;
            end else if (tick && m_count + 32'd1 == m_compare) begin
                m_ti = 1'b1;
            end
            if (wr && cp0_addr == mips_pkg::CP0_COUNT)
                m_count = cp0_wdata;
            else if (tick)
                m_count = m_count + 32'd1;
            m_presc = tick ? 0 : m_presc + 1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_inputs();
        flush = 1'b0;
        exe = '0;
        ext_int = '0;
        d_tlb_invalid = 1'b0;
        tlb_modified = 1'b0;
        cp0_we = 1'b0;
        cp0_addr = '0;
        cp0_wdata = '0;
        eret = 1'b0;
    endtask

    function automatic mips_pkg::exec_data_t random_exe(input mips_pkg::decoded_op_t op);
        mips_pkg::exec_data_t x;
        x = '0;
        x.valid = 1'b1;
        x.op = op;
        x.pcplus4 = {30'($urandom), 2'b00};
        x.result = $urandom;
        x.memtoreg = op inside {mips_pkg::LW, mips_pkg::LH, mips_pkg::LHU, mips_pkg::LB,
                                mips_pkg::LBU};
        x.memwrite = op inside {mips_pkg::SW, mips_pkg::SH, mips_pkg::SB};
        x.in_delay_slot = 1'($urandom % 2);
        x.dest = 5'($urandom);
        return x;
    endfunction

    task automatic write_cp0(input mips_pkg::cp0_addr_t a, input mips_pkg::word_t d);
        next_cycle();
        idle_inputs();
        cp0_we = 1'b1;
        cp0_addr = a;
        cp0_wdata = d;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        next_cycle();
        idle_inputs();
        @(negedge clk);
        #1;
        if (errors == start_errors) begin
            $display("test %s: PASS", name);
            tests_passed++;
        end else begin
            $display("test %s: FAIL with %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic random_faults();
        exe.exception_instr = ($urandom % 6 == 0);
        exe.exception_instr_tlb = ($urandom % 6 == 0);
        exe.exception_ri = ($urandom % 6 == 0);
        exe.exception_of = ($urandom % 6 == 0);
        d_tlb_invalid = ($urandom % 4 == 0);
        tlb_modified = ($urandom % 4 == 0);
    endtask

    initial begin
        int start;
        int waited;
        logic seen;
        void'($urandom(32'h8417bf27));
        idle_inputs();
        wait (!rst);

        // Loads and stores at random addresses with BadVAddr read back
        start = errors;
        repeat (200) begin
            next_cycle();
            idle_inputs();
            exe = random_exe(mips_pkg::decoded_op_t'($urandom % 8));
            cp0_addr = mips_pkg::CP0_BADVADDR;
        end
        finish_test("alignment", start);

        start = errors;
        repeat (200) begin
            next_cycle();
            idle_inputs();
            exe = random_exe(mips_pkg::decoded_op_t'($urandom % 15));
            random_faults();
            cp0_addr = mips_pkg::CP0_BADVADDR;
        end
        finish_test("priority", start);

        // IP2, IP5 and IP7 enabled
        // Second try of a pair finds EXL set when the first was taken
        start = errors;
        next_cycle();
        idle_inputs();
        eret = 1'b1;
        write_cp0(mips_pkg::CP0_STATUS, {16'h0, 8'b1010_0100, 8'h01});
        repeat (30) begin
            next_cycle();
            idle_inputs();
            exe = random_exe(mips_pkg::NOP);
            ext_int = 6'b1 << ($urandom % 6);
            next_cycle();
            ext_int = 6'b1 << ($urandom % 6);
            next_cycle();
            idle_inputs();
            eret = 1'b1;
        end
        finish_test("interrupts", start);

        start = errors;
        repeat (20) begin
            next_cycle();
            idle_inputs();
            eret = 1'b1;
            next_cycle();
            idle_inputs();
            exe = random_exe(mips_pkg::SYSCALL);
            cp0_addr = mips_pkg::CP0_EPC;
            next_cycle();
            idle_inputs();
            cp0_addr = mips_pkg::CP0_CAUSE;
        end
        finish_test("cp0_recording", start);

        start = errors;
        repeat (60) begin
            next_cycle();
            idle_inputs();
            exe = random_exe(mips_pkg::decoded_op_t'($urandom % 15));
            random_faults();
            if ($urandom % 2)
                flush = 1'b1;
            else
                exe.valid = 1'b0;
            cp0_addr = 5'(8 + ($urandom % 7));
        end
        finish_test("suppression", start);

        // Count cleared after Compare so no match can come early
        start = errors;
        next_cycle();
        idle_inputs();
        eret = 1'b1;
        write_cp0(mips_pkg::CP0_STATUS, {16'h0, 8'h80, 8'h01});
        write_cp0(mips_pkg::CP0_COMPARE, TIMER_N);
        write_cp0(mips_pkg::CP0_COUNT, 32'd0);
        waited = 1;
        seen = 1'b0;
        while (!seen && waited < 4 * TIMER_N + 10) begin
            next_cycle();
            idle_inputs();
            exe = random_exe(mips_pkg::NOP);
            cp0_addr = mips_pkg::CP0_COUNT;
            waited++;
            @(negedge clk);
            seen = exception_valid;
        end
        if (!seen) begin
            $display("timer interrupt was not taken within %0d cycles", waited);
            errors++;
        end else if (waited < 2 * TIMER_N || waited > 2 * TIMER_N + 2) begin
            $display("timer interrupt came %0d cycles after the Compare write", waited);
            errors++;
        end
        finish_test("timer", start);

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
common/mips_pkg.sv
common/exc_report_if.sv
exception/exception_priority.sv
exception/exception_checker.sv
verilog/cp0_regs.sv
verilog/exc_unit_top.sv
sim/tb_clock.sv
sim/exc_unit_tb.sv
